// ==== source/spinn_link_pkg.sv ====
// link constants, 2-of-7 code table, symbol and packet types, transition counter
package spinn_link_pkg;

  // ------------------------------------------------
  // link constants
  // ------------------------------------------------
  localparam int SYM_BITS     = 7;   // wires per 2-of-7 symbol
  localparam int NIBBLE_BITS  = 4;   // payload of one data symbol
  localparam int PKT_BITS     = 72;  // long packet and output width
  localparam int SHORT_BITS   = 40;  // short packet, no payload word
  localparam int SHORT_FLITS  = 10;  // flit count where a short packet ends
  localparam int LONG_FLITS   = 18;  // flit count where a long packet ends
  localparam int LEN_FLAG_BIT = 1;   // long packet flag in the first nibble

  // ------------------------------------------------
  // types
  // ------------------------------------------------
  typedef logic [SYM_BITS-1:0] sym_t;  // wire levels of the link

  // class of the change between two symbols
  typedef enum logic [1:0] {
    kind_none,  // zero or one transitions so far
    kind_data,
    kind_eop,
    kind_err
  } sym_kind_t;

  typedef struct packed {
    sym_kind_t               kind;
    logic [NIBBLE_BITS-1:0] nibble;  // only meaningful for kind_data
  } flit_t;

  typedef logic [PKT_BITS-1:0] pkt_t;

  // ------------------------------------------------
  // NRZ transition patterns
  // ------------------------------------------------
  localparam sym_t EOP_CODE = 7'b1100000;  // wires 5 and 6

  // indexed by nibble value
  localparam sym_t DATA_CODES [2**NIBBLE_BITS] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,  // 0..3 wire 4 + low wire
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,  // 4..7 wire 5 + low wire
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,  // 8..11 wire 6 + low wire
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001   // 12..15 neighbours in 0..3
  };

  // number of wires that differ between two symbols
  function automatic logic [2:0] count_trans(input sym_t a, input sym_t b);
    sym_t       d;
    logic [2:0] n;
    d = a ^ b;
    n = '0;
    for (int i = 0; i < SYM_BITS; i++) begin
      n = n + {2'b00, d[i]};
    end
    return n;
  endfunction

endpackage

// ==== source/flit_capture.sv ====
// link front end: two-flop synchroniser, new symbol detect, ack toggle, symbol hold
module flit_capture (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,

  // link side
  input  spinn_link_pkg::sym_t sl_data,
  output logic                 sl_ack,

  // decoder side
  output spinn_link_pkg::sym_t flt_sym,
  input  logic                 flt_rdy
);

  spinn_link_pkg::sym_t sl_meta;   // first sync stage
  spinn_link_pkg::sym_t sl_sync;   // second sync stage, safe to use

  logic start_st;   // high through reset and the first clock after
  logic new_sym;    // two or more wires moved since last accepted symbol
  logic flt_vld;    // flt_sym holds a symbol not yet taken downstream
  logic flt_busy;   // downstream cannot take another symbol
  logic send_ack;   // toggle sl_ack this cycle

  // ------------------------------------------------
  // synchroniser
  // ------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    sl_meta <= sl_data;
    sl_sync <= sl_meta;
  end

  // start flag, the link expects an ack on reset exit
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      start_st <= 1'b1;
    end else begin
      start_st <= 1'b0;
    end
  end

  // ------------------------------------------------
  // symbol detection and ack
  // ------------------------------------------------
  assign new_sym  = (spinn_link_pkg::count_trans(sl_sync, flt_sym) >= 3'd2);
  assign flt_busy = flt_vld && !flt_rdy;
  assign send_ack = start_st || (new_sym && !flt_busy);

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sl_ack <= 1'b0;
    end else if (send_ack) begin
      sl_ack <= ~sl_ack;  // NRZ ack, one toggle per symbol
    end
  end

  // hold register, tracks the wires during reset
  always_ff @(posedge CLK_IN) begin
    if (send_ack) begin
      flt_sym <= sl_sync;
    end
  end

  // valid only for the cycle after capture unless the decoder stalls
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_vld <= 1'b0;
    end else if (!flt_busy) begin
      flt_vld <= new_sym && !start_st;
    end
  end

  // ------------------------------------------------
  // checks
  // ------------------------------------------------
  // sender waits for each ack, so two toggles can never be back to back
  ack_spacing_a : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    $changed(sl_ack) |=> $stable(sl_ack)
  ) else $error("sl_ack toggled on consecutive cycles");

endmodule

// ==== source/symbol_decoder.sv ====
// NRZ 2-of-7 decoder: previous-symbol register and data / eop / error classification
module symbol_decoder (
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,
  input  spinn_link_pkg::sym_t  flt_sym,
  input  logic                  flt_rdy,
  output spinn_link_pkg::flit_t flit
);

  spinn_link_pkg::sym_t prev_sym;  // last symbol consumed
  spinn_link_pkg::sym_t diff;      // wires that moved since then
  logic [2:0]           n_trans;   // how many moved
  logic                 start_st;  // first clock after reset

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      start_st <= 1'b1;
    end else begin
      start_st <= 1'b0;
    end
  end

  // ------------------------------------------------
  // classification
  // ------------------------------------------------
  assign diff    = flt_sym ^ prev_sym;
  assign n_trans = spinn_link_pkg::count_trans(flt_sym, prev_sym);

  always_comb begin
    flit.kind   = spinn_link_pkg::kind_none;
    flit.nibble = '0;  // defined zero when not data
    if (n_trans >= 3'd2) begin
      flit.kind = spinn_link_pkg::kind_err;  // unless a known code matches
      if (diff == spinn_link_pkg::EOP_CODE) begin
        flit.kind = spinn_link_pkg::kind_eop;
      end
      for (int i = 0; i < 2**spinn_link_pkg::NIBBLE_BITS; i++) begin
        if (diff == spinn_link_pkg::DATA_CODES[i]) begin
          flit.kind   = spinn_link_pkg::kind_data;
          flit.nibble = i[spinn_link_pkg::NIBBLE_BITS-1:0];  // table index is the value
        end
      end
    end
  end

  // ------------------------------------------------
  // previous symbol
  // ------------------------------------------------
  // follows flt_sym through reset, then moves on each consumed symbol
  always_ff @(posedge CLK_IN) begin
    if (start_st || (flt_rdy && (flit.kind != spinn_link_pkg::kind_none))) begin
      prev_sym <= flt_sym;
    end
  end

  // ------------------------------------------------
  // checks
  // ------------------------------------------------
  // code table holds only true 2-of-7 patterns
  data_two_trans_a : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    (flit.kind == spinn_link_pkg::kind_data) |-> (n_trans == 3'd2)
  ) else $error("data flit decoded from %0d transitions", n_trans);

endmodule

// ==== source/packet_assembler.sv ====
// packet FSM: flit count, length flag, nibble shift buffer, load towards the output
module packet_assembler (
  input  logic                  CLK_IN,
  input  logic                  RESET_IN,

  // decoder side
  input  spinn_link_pkg::flit_t flit,
  output logic                  flt_rdy,

  // output register side
  input  logic                  pkt_busy,
  output logic                  load,
  output spinn_link_pkg::pkt_t  load_data
);

  typedef enum logic [2:0] {
    st_start,  // one clock after reset
    st_idle,   // between packets
    st_tran,   // packet in progress
    st_wait,   // packet done, output still busy
    st_err     // bad symbol seen, skip to eop
  } state_t;

  state_t state;
  state_t state_nxt;

  logic                 take_dat;   // data nibble consumed this cycle
  logic                 take_eop;
  logic                 take_err;
  logic                 exp_eop;    // eop would end the packet correctly
  logic                 load_nxt;   // hand packet over next cycle
  logic                 long_pkt;   // from bit 1 of the first nibble
  logic [4:0]           flit_cnt;   // data flits in this packet
  spinn_link_pkg::pkt_t pkt_buf;    // nibbles enter at the top

  assign take_dat = flt_rdy && (flit.kind == spinn_link_pkg::kind_data);
  assign take_eop = flt_rdy && (flit.kind == spinn_link_pkg::kind_eop);
  assign take_err = flt_rdy && (flit.kind == spinn_link_pkg::kind_err);

  assign exp_eop = (!long_pkt && (flit_cnt == spinn_link_pkg::SHORT_FLITS))
                || (long_pkt && (flit_cnt == spinn_link_pkg::LONG_FLITS));

  // ------------------------------------------------
  // state machine
  // ------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      st_start:
        state_nxt = st_idle;
      st_idle: begin
        if (take_dat)
          state_nxt = st_tran;  // first nibble of a packet
        else if (take_err)
          state_nxt = st_err;
      end
      st_tran: begin
        if (take_err)
          state_nxt = st_err;   // drop packet
        else if (take_eop && !exp_eop)
          state_nxt = st_idle;  // early or late eop, drop packet
        else if (take_eop && pkt_busy)
          state_nxt = st_wait;
        else if (take_eop)
          state_nxt = st_idle;  // good packet, output free
      end
      st_wait:
        if (!pkt_busy)
          state_nxt = st_idle;
      st_err:
        if (take_eop)
          state_nxt = st_idle;  // resync on eop
      default:
        state_nxt = st_err;
    endcase
  end

  assign load_nxt = !pkt_busy && (((state == st_tran) && take_eop && exp_eop)
                                 || (state == st_wait));

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state   <= st_start;
      flt_rdy <= 1'b0;
      load    <= 1'b0;
    end else begin
      state   <= state_nxt;
      flt_rdy <= (state_nxt != st_wait);  // stall the link while waiting
      load    <= load_nxt;
    end
  end

  // ------------------------------------------------
  // flit count and length flag
  // ------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_cnt <= 5'd1;
      long_pkt <= 1'b0;
    end else begin
      if (state != st_tran)
        flit_cnt <= 5'd1;             // first nibble counts as 1
      else if (take_dat)
        flit_cnt <= flit_cnt + 5'd1;
      if ((state == st_idle) && take_dat)
        long_pkt <= flit.nibble[spinn_link_pkg::LEN_FLAG_BIT];
    end
  end

  // ------------------------------------------------
  // packet buffer
  // ------------------------------------------------
  // nibble i ends at bits 4i+3..4i of a long packet
  always_ff @(posedge CLK_IN) begin
    if (take_dat) begin
      pkt_buf <= {flit.nibble, pkt_buf[spinn_link_pkg::PKT_BITS-1:spinn_link_pkg::NIBBLE_BITS]};
    end
  end

  // short packets sit high in the buffer, shift down and zero the top
  always_ff @(posedge CLK_IN) begin
    if (load_nxt) begin
      if (long_pkt)
        load_data <= pkt_buf;
      else
        load_data <= pkt_buf >> (spinn_link_pkg::PKT_BITS - spinn_link_pkg::SHORT_BITS);
    end
  end

endmodule

// ==== source/packet_output.sv ====
// output packet register with valid held under back-pressure
module packet_output (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,

  // assembler side
  input  logic                 load,
  input  spinn_link_pkg::pkt_t load_data,

  // packet interface
  output spinn_link_pkg::pkt_t pkt_data,
  output logic                 pkt_vld,
  input  logic                 pkt_rdy,

  output logic                 pkt_busy
);

  // ------------------------------------------------
  // data and valid
  // ------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (load) begin
      pkt_data <= load_data;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
    end else if (load) begin
      pkt_vld <= 1'b1;
    end else if (pkt_rdy) begin
      pkt_vld <= 1'b0;  // taken, nothing new behind it
    end
  end

  // packet waiting and not taken
  assign pkt_busy = pkt_vld && !pkt_rdy;

  // ------------------------------------------------
  // checks
  // ------------------------------------------------
  // assembler must never load over a held packet
  pkt_hold_a : assert property (
    @(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt_data))
  ) else $error("packet changed under back-pressure");

endmodule

// ==== source/spinn_link_receiver.sv ====
// receiver top: capture, decoder, assembler and output register
module spinn_link_receiver (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,

  // SpiNNaker link
  input  spinn_link_pkg::sym_t sl_data,
  output logic                 sl_ack,

  // packet interface
  output spinn_link_pkg::pkt_t pkt_data,
  output logic                 pkt_vld,
  input  logic                 pkt_rdy
);

  spinn_link_pkg::sym_t  flt_sym;    // latest accepted wire state
  spinn_link_pkg::flit_t flit;       // decoded symbol
  logic                  flt_rdy;    // assembler takes symbols
  logic                  load;       // packet complete
  spinn_link_pkg::pkt_t  load_data;
  logic                  pkt_busy;   // output holds an untaken packet

  flit_capture i_capture (
    .CLK_IN, .RESET_IN,
    .sl_data, .sl_ack,
    .flt_sym, .flt_rdy
  );

  symbol_decoder i_decoder (
    .CLK_IN, .RESET_IN,
    .flt_sym, .flt_rdy,
    .flit
  );

  packet_assembler i_assembler (
    .CLK_IN, .RESET_IN,
    .flit, .flt_rdy,
    .pkt_busy, .load, .load_data
  );

  packet_output i_output (
    .CLK_IN, .RESET_IN,
    .load, .load_data,
    .pkt_data, .pkt_vld, .pkt_rdy,
    .pkt_busy
  );

endmodule

// ==== bench/tb_spinn_link_receiver.sv ====
// testbench: clock, reset, link sender model, LFSR, reference packet builder, checker, tests
module tb_spinn_link_receiver;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SHORT_SYMS  = spinn_link_pkg::SHORT_FLITS + 1;  // nibbles plus eop
  localparam int LONG_SYMS   = spinn_link_pkg::LONG_FLITS + 1;
  // 8 short, 4 long, the error packet (20) and the early eop packet (6)
  localparam int N_SYMS      = 8 * SHORT_SYMS + 4 * LONG_SYMS + 20 + 6;
  localparam int CYCLE_LIMIT = 40 * N_SYMS + 200;
  localparam spinn_link_pkg::sym_t ERR_CODE = 7'b0000111;  // three wires, matches no code

  logic                  CLK_IN;
  logic                  RESET_IN;
  spinn_link_pkg::sym_t  sl_data;
  logic                  sl_ack;
  spinn_link_pkg::pkt_t  pkt_data;
  logic                  pkt_vld;
  logic                  pkt_rdy;

  logic [31:0]           lfsr;          // stimulus source
  spinn_link_pkg::pkt_t  exp_q [$];     // packets still owed by the DUT
  spinn_link_pkg::pkt_t  data_prev;
  logic                  hold_prev;     // output was stalled last edge
  logic                  ack_q;
  logic                  senders_done;
  int n_errors, n_tests, n_failed, sym_sent, ack_toggles, cycles;

  spinn_link_receiver i_dut (
    .CLK_IN(CLK_IN), .RESET_IN(RESET_IN),
    .sl_data(sl_data), .sl_ack(sl_ack),
    .pkt_data(pkt_data), .pkt_vld(pkt_vld), .pkt_rdy(pkt_rdy)
  );

  always #10 CLK_IN = ~CLK_IN;  // 20 ns

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      r    = {r[30:0], lfsr[0]};
    end
  endtask

  // nibble i lands at bits 4i+3..4i, anything above stays zero
  function automatic spinn_link_pkg::pkt_t expected_packet(input logic [3:0] nibs [$]);
    spinn_link_pkg::pkt_t p;
    p = '0;
    foreach (nibs[i]) p[4*i +: 4] = nibs[i];
    return p;
  endfunction

  task automatic check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  // random gap, NRZ wire change, then block until the ack toggles
  task automatic send_sym(input spinn_link_pkg::sym_t code);
    logic [31:0] gap;
    logic        ack_before;
    rand_bits(2, gap);
    repeat (gap[1:0]) @(posedge CLK_IN);
    ack_before = sl_ack;
    sl_data <= sl_data ^ code;
    do @(posedge CLK_IN); while (sl_ack == ack_before);
    sym_sent++;
  endtask

  // random nibbles, the first one carries the length flag
  task automatic send_nibbles(input int n, input logic long_flag);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      rand_bits(4, r);
      if (i == 0) r[spinn_link_pkg::LEN_FLAG_BIT] = long_flag;
      send_sym(spinn_link_pkg::DATA_CODES[r[3:0]]);
    end
  endtask

  // n nibbles then eop, keep means the DUT must deliver it
  task automatic send_packet(input int n_nib, input logic long_flag, input logic keep);
    logic [3:0]  nibs [$];
    logic [31:0] r;
    for (int i = 0; i < n_nib; i++) begin
      rand_bits(4, r);
      if (i == 0) r[spinn_link_pkg::LEN_FLAG_BIT] = long_flag;
      nibs.push_back(r[3:0]);
    end
    if (keep) exp_q.push_back(expected_packet(nibs));
    foreach (nibs[i]) send_sym(spinn_link_pkg::DATA_CODES[nibs[i]]);
    send_sym(spinn_link_pkg::EOP_CODE);
  endtask

  task automatic drain_packets();
    while (exp_q.size() != 0) @(posedge CLK_IN);
    repeat (4) @(posedge CLK_IN);  // room for a stray extra packet
  endtask

  task automatic finish_test(input string title, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, title);
    end else begin
      $display("test %0d %s: %0d mismatches", n_tests, title, n_errors - errs_before);
      n_failed++;
    end
  endtask

  // ------------------------------------------------
  // monitors
  // ------------------------------------------------
  always @(posedge CLK_IN) begin
    if (!RESET_IN) begin
      if (hold_prev) begin  // stalled packet must not move
        check_value("pkt_vld", pkt_vld, 1'b1);
        check_value("pkt_data", pkt_data, data_prev);
      end
      if (pkt_vld && pkt_rdy) begin
        if (exp_q.size() == 0) begin
          $display("a packet %h arrived that was not expected", pkt_data);
          n_errors++;
        end else begin
          check_value("pkt_data", pkt_data, exp_q.pop_front());
        end
      end
    end
    hold_prev = pkt_vld && !pkt_rdy && !RESET_IN;
    data_prev = pkt_data;
  end

  always @(posedge CLK_IN) begin
    if (!RESET_IN && (sl_ack !== ack_q)) ack_toggles++;
    ack_q = sl_ack;
  end

  always @(posedge CLK_IN) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  initial begin
    int e0;
    int stalled_at;
    CLK_IN = 1'b0;
    RESET_IN = 1'b1;
    sl_data = '0;
    pkt_rdy = 1'b1;
    lfsr = 32'h0681f515;
    ack_q = 1'b0;
    hold_prev = 1'b0;
    senders_done = 1'b0;
    repeat (10) @(posedge CLK_IN);
    RESET_IN <= 1'b0;

    e0 = n_errors;  // ack on reset exit, no symbol sent
    repeat (10) @(posedge CLK_IN);
    check_value("ack_toggles", ack_toggles, 1);
    check_value("sl_ack", sl_ack, 1'b1);
    check_value("pkt_vld", pkt_vld, 1'b0);
    finish_test("reset ack", e0);

    e0 = n_errors;
    repeat (4) send_packet(spinn_link_pkg::SHORT_FLITS, 1'b0, 1'b1);
    drain_packets();
    finish_test("short packets", e0);

    e0 = n_errors;
    repeat (3) send_packet(spinn_link_pkg::LONG_FLITS, 1'b1, 1'b1);
    drain_packets();
    finish_test("long packets", e0);

    e0 = n_errors;
    send_nibbles(8, 1'b1);   // long header, 18 nibbles in all around the error
    send_sym(ERR_CODE);      // packet dropped, skip to eop
    send_nibbles(10, 1'b0);  // a full short packet, skipped as well
    send_sym(spinn_link_pkg::EOP_CODE);
    send_packet(spinn_link_pkg::SHORT_FLITS, 1'b0, 1'b1);
    send_packet(5, 1'b0, 1'b0);  // eop too early
    send_packet(spinn_link_pkg::LONG_FLITS, 1'b1, 1'b1);
    drain_packets();
    finish_test("dropped packets", e0);

    e0 = n_errors;
    pkt_rdy <= 1'b0;
    fork
      begin
        repeat (3) send_packet(spinn_link_pkg::SHORT_FLITS, 1'b0, 1'b1);
        senders_done = 1'b1;
      end
    join_none
    while (!pkt_vld) @(posedge CLK_IN);
    repeat (300) @(posedge CLK_IN);
    stalled_at = sym_sent;
    repeat (40) @(posedge CLK_IN);
    check_value("sym_sent", sym_sent, stalled_at);  // link stalled
    check_value("senders_done", senders_done, 1'b0);
    check_value("pkt_data", pkt_data, exp_q[0]);
    pkt_rdy <= 1'b1;
    while (!senders_done || (exp_q.size() != 0)) @(posedge CLK_IN);
    finish_test("back-pressure", e0);

    e0 = n_errors;
    repeat (4) @(posedge CLK_IN);
    check_value("ack_toggles", ack_toggles, sym_sent + 1);
    finish_test("ack count", e0);

    $display("%0d tests, %0d failed, %0d mismatches, %0d symbols, %0d ack toggles",
             n_tests, n_failed, n_errors, sym_sent, ack_toggles);
    if ((n_errors == 0) && (n_failed == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/spinn_link_pkg.sv
source/flit_capture.sv
source/symbol_decoder.sv
source/packet_assembler.sv
source/packet_output.sv
source/spinn_link_receiver.sv
bench/tb_spinn_link_receiver.sv
